// File: verilog.f
rename_pkg.sv
rename_ifs.sv
map_table.sv
free_list.sv
rename_group.sv
renamer_top.sv
tb_renamer.sv

// File: Makefile
SIM      = verilator
TOP      = tb_renamer
FILELIST = verilog.f
FLAGS    = --binary --timing --assert
OBJDIR   = obj_dir
PASS_MSG = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: tb_renamer.sv
`timescale 1ns/1ps

module tb_renamer;

    typedef logic [rename_pkg::group_w*rename_pkg::uop_w-1:0]         group_word_t;
    typedef rename_pkg::renamed_op_t [rename_pkg::group_w-1:0]        ops_pair_t;
    typedef logic [rename_pkg::group_w-1:0][rename_pkg::preg_w-1:0]   old_pair_t;

    // the exhaustion loop and the 22 commits make up most of the run
    localparam int max_cycles = 400;

    logic                          clk;
    logic                          rst;
    logic                          in_valid;
    logic                          in_ready;
    group_word_t                   in_ops;
    logic                          out_valid;
    logic                          out_ready;
    ops_pair_t                     out_ops;
    old_pair_t                     out_old_preg;
    logic                          cmplt_valid;
    logic [rename_pkg::preg_w-1:0] cmplt_preg;
    logic                          commit_valid;
    logic [rename_pkg::preg_w-1:0] commit_preg;

    // reference model of alias table, done flags and free pool
    logic [rename_pkg::preg_w-1:0]    alias_map [rename_pkg::arch_regs];
    logic [rename_pkg::phys_regs-1:0] done_vec;
    logic [rename_pkg::phys_regs-1:0] free_vec;
    ops_pair_t                        want_ops_q [$];
    old_pair_t                        want_old_q [$];
    ops_pair_t                        last_ops;
    old_pair_t                        last_old;

    int seed      = 74;
    int errors    = 0;
    int checks    = 0;
    int tests     = 0;
    int cycle_cnt = 0;

    renamer_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_ops       (in_ops),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_ops      (out_ops),
        .out_old_preg (out_old_preg),
        .cmplt_valid  (cmplt_valid),
        .cmplt_preg   (cmplt_preg),
        .commit_valid (commit_valid),
        .commit_preg  (commit_preg)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic rename_pkg::micro_op_u reg_op(input logic [3:0] opc,
            input logic [2:0] dst, input logic [2:0] src1, input logic [2:0] src2);
        rename_pkg::micro_op_u u;
        u.reg_form.opcode = opc;
        u.reg_form.dst    = dst;
        u.reg_form.src1   = src1;
        u.reg_form.src2   = src2;
        u.reg_form.pad    = '0;
        return u;
    endfunction

    function automatic rename_pkg::micro_op_u imm_op(input logic [3:0] opc,
            input logic [2:0] dst, input logic [2:0] src1, input logic [13:0] imm);
        rename_pkg::micro_op_u u;
        u.imm_form.opcode = opc;
        u.imm_form.dst    = dst;
        u.imm_form.src1   = src1;
        u.imm_form.imm    = imm;
        return u;
    endfunction

    // lane0 goes in the low half
    function automatic group_word_t pack_group(input rename_pkg::micro_op_u lane0,
            input rename_pkg::micro_op_u lane1);
        return {lane1, lane0};
    endfunction

    function automatic logic [4:0] lowest_free(input logic [31:0] pool);
        logic [4:0] idx;
        idx = '0;
        for (int i = rename_pkg::phys_regs - 1; i >= 0; i--) begin
            if (pool[i]) begin
                idx = 5'(i);
            end
        end
        return idx;
    endfunction

    function automatic int free_count();
        return $countones(free_vec);
    endfunction

    // a completion arriving in the accept cycle already counts
    function automatic logic ready_of(input logic [4:0] p);
        return done_vec[p] || (cmplt_valid && cmplt_preg == p);
    endfunction

    task automatic check_renamed(input string name, input rename_pkg::renamed_op_t got,
            input rename_pkg::renamed_op_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error %s got %h expected %h", name, got, want);
        end
    endtask

    task automatic check_preg(input string name, input logic [rename_pkg::preg_w-1:0] got,
            input logic [rename_pkg::preg_w-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error %s got %h expected %h", name, got, want);
        end
    endtask

    task automatic confirm(input logic cond, input string what);
        checks++;
        if (cond !== 1'b1) begin
            errors++;
            $display("%s", what);
        end
    endtask

    // expected group from the current model state, then the model update
    task automatic predict_group(input group_word_t ops);
        rename_pkg::micro_op_u uop [2];
        logic [1:0]            wr;
        logic [4:0]            newp [2];
        logic [31:0]           pool;
        ops_pair_t             want;
        old_pair_t             old;
        uop[0] = ops[23:0];
        uop[1] = ops[47:24];
        pool   = free_vec;
        for (int k = 0; k < 2; k++) begin
            wr[k]   = uop[k].reg_form.opcode != rename_pkg::op_nop;
            newp[k] = '0;
            if (wr[k]) begin
                newp[k]       = lowest_free(pool);
                pool[newp[k]] = 1'b0;
            end
        end
        for (int k = 0; k < 2; k++) begin
            want[k].opcode     = uop[k].reg_form.opcode;
            want[k].is_imm     = uop[k].reg_form.opcode[3];
            want[k].dst_preg   = newp[k];
            want[k].src1_preg  = alias_map[uop[k].reg_form.src1];
            want[k].src1_ready = ready_of(want[k].src1_preg);
            want[k].src2_preg  = alias_map[uop[k].reg_form.src2];
            want[k].src2_ready = ready_of(want[k].src2_preg);
            want[k].imm        = '0;
            old[k]             = wr[k] ? alias_map[uop[k].reg_form.dst] : '0;
        end
        if (wr[0]) begin
            if (uop[1].reg_form.src1 == uop[0].reg_form.dst) begin
                want[1].src1_preg  = newp[0];
                want[1].src1_ready = 1'b0;
            end
            if (uop[1].reg_form.src2 == uop[0].reg_form.dst) begin
                want[1].src2_preg  = newp[0];
                want[1].src2_ready = 1'b0;
            end
            if (wr[1] && uop[1].reg_form.dst == uop[0].reg_form.dst) begin
                old[1] = newp[0];
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (want[k].is_imm) begin
                want[k].src2_preg  = '0;
                want[k].src2_ready = 1'b1;
                want[k].imm        = uop[k].imm_form.imm;
            end
        end
        want_ops_q.push_back(want);
        want_old_q.push_back(old);
        for (int k = 0; k < 2; k++) begin
            if (wr[k]) begin
                alias_map[uop[k].reg_form.dst] = newp[k];
                done_vec[newp[k]]              = 1'b0;
            end
        end
        free_vec = pool;
    endtask

    task automatic compare_output();
        ops_pair_t want;
        old_pair_t old;
        if (want_ops_q.size() == 0) begin
            errors++;
            $display("an output group appeared with no group outstanding");
        end else begin
            want = want_ops_q.pop_front();
            old  = want_old_q.pop_front();
            for (int k = 0; k < 2; k++) begin
                check_renamed($sformatf("out_ops[%0d]", k), out_ops[k], want[k]);
                check_preg($sformatf("out_old_preg[%0d]", k), out_old_preg[k], old[k]);
            end
        end
        last_ops = out_ops;
        last_old = out_old_preg;
    endtask

    // model samples the handshakes at the rising edge, before the DUT updates
    initial begin : model
        forever begin
            @(posedge clk);
            if (rst) begin
                for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                    alias_map[i] = 5'(i);
                end
                done_vec = 32'h0000_00ff;
                free_vec = 32'hffff_ff00;
            end else begin
                if (out_valid && out_ready) begin
                    compare_output();
                end
                if (cmplt_valid) begin
                    done_vec[cmplt_preg] = 1'b1;
                end
                if (in_valid && in_ready) begin
                    predict_group(in_ops);
                end
                if (commit_valid) begin
                    free_vec[commit_preg] = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, the run did not finish within %0d cycles", max_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // offer a group and return on the falling edge after it is taken
    task automatic push_group(input group_word_t ops);
        in_valid = 1'b1;
        in_ops   = ops;
        @(posedge clk);
        while (in_ready !== 1'b1) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic drain_outputs();
        in_valid  = 1'b0;
        out_ready = 1'b1;
        while (want_ops_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    task automatic reset_mapping();
        confirm(out_valid === 1'b0, "out_valid is high right after reset");
        confirm(in_ready === 1'b1, "in_ready is low right after reset");
        push_group(pack_group(reg_op(4'd1, 3'd1, 3'd2, 3'd3), reg_op(4'd2, 3'd4, 3'd5, 3'd6)));
        drain_outputs();
        check_preg("out_ops[0].dst_preg", last_ops[0].dst_preg, 5'd8);
        check_preg("out_ops[1].dst_preg", last_ops[1].dst_preg, 5'd9);
        check_preg("out_ops[0].src1_preg", last_ops[0].src1_preg, 5'd2);
        check_preg("out_ops[1].src2_preg", last_ops[1].src2_preg, 5'd6);
        check_preg("out_old_preg[0]", last_old[0], 5'd1);
        check_preg("out_old_preg[1]", last_old[1], 5'd4);
        confirm(last_ops[0].src1_ready && last_ops[1].src2_ready,
                "a source on its reset alias was not ready");
        end_test("reset mapping");
    endtask

    task automatic group_bypass();
        // lane1 reads and rewrites r2 which lane0 writes
        push_group(pack_group(reg_op(4'd3, 3'd2, 3'd1, 3'd0), reg_op(4'd4, 3'd2, 3'd2, 3'd7)));
        drain_outputs();
        check_preg("out_ops[0].dst_preg", last_ops[0].dst_preg, 5'd10);
        check_preg("out_ops[1].dst_preg", last_ops[1].dst_preg, 5'd11);
        check_preg("out_ops[1].src1_preg", last_ops[1].src1_preg, 5'd10);
        check_preg("out_old_preg[1]", last_old[1], 5'd10);
        confirm(last_ops[1].src1_ready === 1'b0, "lane1 source from lane0 was marked ready");
        end_test("intra-group bypass");
    endtask

    task automatic imm_and_nop();
        logic [31:0] rnd;
        rnd = $random(seed);
        push_group(pack_group(imm_op(4'd9, 3'd3, 3'd4, rnd[13:0]),
                              reg_op(4'd0, 3'd5, 3'd6, 3'd7)));
        drain_outputs();
        check_preg("out_ops[0].dst_preg", last_ops[0].dst_preg, 5'd12);
        check_preg("out_ops[0].src2_preg", last_ops[0].src2_preg, 5'd0);
        check_preg("out_ops[1].dst_preg", last_ops[1].dst_preg, 5'd0);
        check_preg("out_old_preg[1]", last_old[1], 5'd0);
        confirm(last_ops[0].is_imm && last_ops[0].src2_ready,
                "immediate op lacks is_imm or a ready second source");
        confirm(last_ops[0].imm === rnd[13:0], $sformatf("error out_ops[0].imm got %h expected %h",
                last_ops[0].imm, rnd[13:0]));
        end_test("immediate and nop");
    endtask

    task automatic completion_lookup();
        cmplt_valid = 1'b1;
        cmplt_preg  = 5'd8;
        @(negedge clk);
        // p9 completes in the same cycle the group is taken
        cmplt_preg = 5'd9;
        push_group(pack_group(reg_op(4'd5, 3'd5, 3'd1, 3'd4), reg_op(4'd6, 3'd6, 3'd4, 3'd1)));
        cmplt_valid = 1'b0;
        drain_outputs();
        check_preg("out_ops[0].dst_preg", last_ops[0].dst_preg, 5'd13);
        confirm(last_ops[0].src1_ready && last_ops[0].src2_ready &&
                last_ops[1].src1_ready && last_ops[1].src2_ready,
                "a completed source was reported not ready");
        end_test("completion lookup");
    endtask

    task automatic exhaustion_release();
        group_word_t blocked;
        blocked = pack_group(reg_op(4'd1, 3'd1, 3'd0, 3'd0), reg_op(4'd2, 3'd2, 3'd3, 3'd4));
        // leave exactly one register in the pool
        while (free_count() >= 3) begin
            push_group(pack_group(reg_op(4'd7, 3'd7, 3'd1, 3'd2), reg_op(4'd2, 3'd0, 3'd7, 3'd3)));
        end
        if (free_count() == 2) begin
            push_group(pack_group(reg_op(4'd7, 3'd7, 3'd1, 3'd2), reg_op(4'd0, 3'd0, 3'd0, 3'd0)));
        end
        in_valid = 1'b1;
        in_ops   = blocked;
        confirm(in_ready === 1'b0,
                "in_ready is high with one register free for a group that needs two");
        @(negedge clk);
        confirm(in_ready === 1'b0, "in_ready rose with only one register free");
        commit_valid = 1'b1;
        commit_preg  = 5'd8;
        @(negedge clk);
        commit_valid = 1'b0;
        confirm(in_ready === 1'b1, "in_ready stayed low after a register was committed");
        push_group(blocked);
        drain_outputs();
        check_preg("out_ops[0].dst_preg", last_ops[0].dst_preg, 5'd8);
        end_test("exhaustion and release");
    endtask

    task automatic backpressure_drain();
        ops_pair_t   held;
        logic [31:0] rnd0;
        logic [31:0] rnd1;
        for (int p = 9; p < 31; p++) begin
            commit_valid = 1'b1;
            commit_preg  = 5'(p);
            @(negedge clk);
        end
        commit_valid = 1'b0;
        out_ready    = 1'b0;
        push_group(pack_group(reg_op(4'd3, 3'd4, 3'd5, 3'd6), reg_op(4'd0, 3'd0, 3'd0, 3'd0)));
        in_valid = 1'b0;
        held     = out_ops;
        confirm(out_valid === 1'b1, "out_valid is low with a group held");
        confirm(in_ready === 1'b0, "in_ready is high while the output is stalled");
        repeat (3) begin
            @(negedge clk);
            check_renamed("out_ops[0]", out_ops[0], held[0]);
            check_renamed("out_ops[1]", out_ops[1], held[1]);
        end
        out_ready = 1'b1;
        for (int g = 0; g < 10; g++) begin
            rnd0 = $random(seed);
            rnd1 = $random(seed);
            push_group({rnd1[23:0], rnd0[23:0]});
        end
        drain_outputs();
        end_test("back-pressure and random drain");
    endtask

    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_ops       = '0;
        out_ready    = 1'b1;
        cmplt_valid  = 1'b0;
        cmplt_preg   = '0;
        commit_valid = 1'b0;
        commit_preg  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_mapping();
        group_bypass();
        imm_and_nop();
        completion_lookup();
        exhaustion_release();
        backpressure_drain();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: renamer_top.sv
`timescale 1ns/1ps

module renamer_top (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic                                                   in_valid,
    output logic                                                   in_ready,
    input  logic [rename_pkg::group_w*rename_pkg::uop_w-1:0]       in_ops,
    output logic                                                   out_valid,
    input  logic                                                   out_ready,
    output rename_pkg::renamed_op_t [rename_pkg::group_w-1:0]      out_ops,
    output logic [rename_pkg::group_w-1:0][rename_pkg::preg_w-1:0] out_old_preg,
    input  logic                                                   cmplt_valid,
    input  logic [rename_pkg::preg_w-1:0]                          cmplt_preg,
    input  logic                                                   commit_valid,
    input  logic [rename_pkg::preg_w-1:0]                          commit_preg
);

    map_if   map_bus ();
    alloc_if alloc_bus ();

    map_table map0 (
        .clk         (clk),
        .rst         (rst),
        .tbl         (map_bus.tbl),
        .cmplt_valid (cmplt_valid),
        .cmplt_preg  (cmplt_preg)
    );

    free_list free0 (
        .clk          (clk),
        .rst          (rst),
        .pool         (alloc_bus.pool),
        .commit_valid (commit_valid),
        .commit_preg  (commit_preg)
    );

    // lane0 sits in the low half of in_ops
    rename_group group0 (
        .clk          (clk),
        .rst          (rst),
        .lookup       (map_bus.lookup),
        .request      (alloc_bus.request),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_ops       (in_ops),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_ops      (out_ops),
        .out_old_preg (out_old_preg)
    );

endmodule

// File: rename_group.sv
`timescale 1ns/1ps

module rename_group (
    input  logic                                                   clk,
    input  logic                                                   rst,
    map_if.lookup                                                  lookup,
    alloc_if.request                                               request,
    input  logic                                                   in_valid,
    output logic                                                   in_ready,
    input  rename_pkg::micro_op_u [rename_pkg::group_w-1:0]        in_ops,
    output logic                                                   out_valid,
    input  logic                                                   out_ready,
    output rename_pkg::renamed_op_t [rename_pkg::group_w-1:0]      out_ops,
    output logic [rename_pkg::group_w-1:0][rename_pkg::preg_w-1:0] out_old_preg
);

    logic                                                   accept;
    logic [rename_pkg::group_w-1:0]                         has_dst;
    logic [rename_pkg::group_w-1:0]                         is_imm;
    logic [rename_pkg::group_w-1:0][rename_pkg::preg_w-1:0] new_preg;
    logic [rename_pkg::group_w-1:0][rename_pkg::preg_w-1:0] s1_preg;
    logic [rename_pkg::group_w-1:0][rename_pkg::preg_w-1:0] s2_preg;
    logic [rename_pkg::group_w-1:0]                         s1_rdy;
    logic [rename_pkg::group_w-1:0]                         s2_rdy;
    logic [rename_pkg::group_w-1:0][rename_pkg::preg_w-1:0] old_next;
    logic                                                   byp_s1;
    logic                                                   byp_s2;
    logic                                                   same_dst;
    rename_pkg::renamed_op_t [rename_pkg::group_w-1:0]      pkt;

    // free a slot when empty or when the held group leaves this cycle
    assign in_ready = (!out_valid || out_ready) && request.enough;
    assign accept   = in_valid && in_ready;

    always_comb begin
        for (int k = 0; k < rename_pkg::group_w; k++) begin
            is_imm[k]  = in_ops[k].reg_form.opcode[3];
            has_dst[k] = in_ops[k].reg_form.opcode != rename_pkg::op_nop;
        end
    end

    assign request.need = {1'b0, has_dst[0]} + {1'b0, has_dst[1]};
    assign request.take = accept;

    // lane1 takes slot 1 only when lane0 already used slot 0
    assign new_preg[0] = request.grant_preg[0];
    assign new_preg[1] = has_dst[0] ? request.grant_preg[1] : request.grant_preg[0];

    always_comb begin
        for (int k = 0; k < rename_pkg::group_w; k++) begin
            lookup.src_idx[2*k]   = in_ops[k].reg_form.src1;
            lookup.src_idx[2*k+1] = in_ops[k].reg_form.src2;
            lookup.dst_idx[k]     = in_ops[k].reg_form.dst;
        end
    end

    assign lookup.wr_en    = has_dst & {rename_pkg::group_w{accept}};
    assign lookup.new_preg = new_preg;
    assign lookup.update   = accept;

    // intra-group dependencies on lane0's destination
    assign byp_s1   = has_dst[0] && in_ops[1].reg_form.src1 == in_ops[0].reg_form.dst;
    assign byp_s2   = has_dst[0] && in_ops[1].reg_form.src2 == in_ops[0].reg_form.dst;
    assign same_dst = has_dst[0] && in_ops[1].reg_form.dst == in_ops[0].reg_form.dst;

    assign s1_preg[0] = lookup.src_preg[0];
    assign s1_rdy[0]  = lookup.src_ready[0];
    assign s2_preg[0] = lookup.src_preg[1];
    assign s2_rdy[0]  = lookup.src_ready[1];
    assign s1_preg[1] = byp_s1 ? new_preg[0] : lookup.src_preg[2];
    assign s1_rdy[1]  = !byp_s1 && lookup.src_ready[2];
    assign s2_preg[1] = byp_s2 ? new_preg[0] : lookup.src_preg[3];
    assign s2_rdy[1]  = !byp_s2 && lookup.src_ready[3];

    always_comb begin
        for (int k = 0; k < rename_pkg::group_w; k++) begin
            pkt[k].opcode     = in_ops[k].reg_form.opcode;
            pkt[k].is_imm     = is_imm[k];
            pkt[k].dst_preg   = has_dst[k] ? new_preg[k] : '0;
            pkt[k].src1_preg  = s1_preg[k];
            pkt[k].src1_ready = s1_rdy[k];
            // immediate form has no second source
            pkt[k].src2_preg  = is_imm[k] ? '0 : s2_preg[k];
            pkt[k].src2_ready = is_imm[k] || s2_rdy[k];
            pkt[k].imm        = is_imm[k] ? in_ops[k].imm_form.imm : '0;
        end
        old_next[0] = has_dst[0] ? lookup.old_preg[0] : '0;
        old_next[1] = !has_dst[1] ? '0 : (same_dst ? new_preg[0] : lookup.old_preg[1]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_ops      <= pkt;
            out_old_preg <= old_next;
        end
    end

    // upstream keeps an offered group steady until it is taken
    a_in_hold_until_accept: assert property (
        @(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_ops)
    );

endmodule

// File: free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                          clk,
    input  logic                          rst,
    alloc_if.pool                         pool,
    input  logic                          commit_valid,
    input  logic [rename_pkg::preg_w-1:0] commit_preg
);

    logic [rename_pkg::phys_regs-1:0] free_q;
    logic [rename_pkg::preg_w-1:0]    first_preg;
    logic [rename_pkg::preg_w-1:0]    second_preg;
    logic                             found_first;
    logic                             found_second;
    logic [rename_pkg::preg_w:0]      free_cnt;

    // priority scan for the two lowest free registers
    always_comb begin
        first_preg   = '0;
        second_preg  = '0;
        found_first  = 1'b0;
        found_second = 1'b0;
        for (int i = 0; i < rename_pkg::phys_regs; i++) begin
            if (free_q[i] && found_first && !found_second) begin
                second_preg  = rename_pkg::preg_w'(i);
                found_second = 1'b1;
            end
            if (free_q[i] && !found_first) begin
                first_preg  = rename_pkg::preg_w'(i);
                found_first = 1'b1;
            end
        end
    end

    assign free_cnt = ($bits(free_cnt))'($countones(free_q));

    assign pool.grant_preg[0] = first_preg;
    assign pool.grant_preg[1] = second_preg;
    assign pool.enough        = free_cnt >= ($bits(free_cnt))'(pool.need);

    always_ff @(posedge clk) begin
        if (rst) begin
            free_q <= rename_pkg::reset_free;
        end else begin
            if (pool.take && pool.need != 2'd0) begin
                free_q[first_preg] <= 1'b0;
            end
            if (pool.take && pool.need == 2'd2) begin
                free_q[second_preg] <= 1'b0;
            end
            // released register shows up in the scan next cycle
            if (commit_valid) begin
                free_q[commit_preg] <= 1'b1;
            end
        end
    end

    a_commit_not_free: assert property (
        @(posedge clk) disable iff (rst)
        commit_valid |-> !free_q[commit_preg]
    );

    a_commit_after_reset: assert property (
        @(posedge clk)
        $past(rst) && !rst && commit_valid |->
            commit_preg >= rename_pkg::preg_w'(rename_pkg::arch_regs)
    );

endmodule

// File: map_table.sv
`timescale 1ns/1ps

module map_table (
    input  logic                          clk,
    input  logic                          rst,
    map_if.tbl                            tbl,
    input  logic                          cmplt_valid,
    input  logic [rename_pkg::preg_w-1:0] cmplt_preg
);

    // current alias per architectural register
    logic [rename_pkg::preg_w-1:0]    alias_tbl [rename_pkg::arch_regs];
    // value present flag per physical register
    logic [rename_pkg::phys_regs-1:0] done_q;

    // combinational lookups, a completion in this cycle counts as ready
    always_comb begin
        for (int k = 0; k < 2 * rename_pkg::group_w; k++) begin
            tbl.src_preg[k]  = alias_tbl[tbl.src_idx[k]];
            tbl.src_ready[k] = done_q[alias_tbl[tbl.src_idx[k]]] |
                               (cmplt_valid && cmplt_preg == alias_tbl[tbl.src_idx[k]]);
        end
        for (int k = 0; k < rename_pkg::group_w; k++) begin
            tbl.old_preg[k] = alias_tbl[tbl.dst_idx[k]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                alias_tbl[i] <= rename_pkg::reset_alias(i);
            end
            done_q <= rename_pkg::reset_done;
        end else begin
            if (cmplt_valid) begin
                done_q[cmplt_preg] <= 1'b1;
            end
            // lanes applied in order so the younger lane wins on a shared dst
            if (tbl.update) begin
                for (int k = 0; k < rename_pkg::group_w; k++) begin
                    if (tbl.wr_en[k]) begin
                        alias_tbl[tbl.dst_idx[k]] <= tbl.new_preg[k];
                        done_q[tbl.new_preg[k]]   <= 1'b0;
                    end
                end
            end
        end
    end

    // a register handed out by the free list cannot complete in the same cycle
    a_no_cmplt_on_alloc: assert property (
        @(posedge clk) disable iff (rst)
        cmplt_valid && tbl.update |->
            !(tbl.wr_en[0] && tbl.new_preg[0] == cmplt_preg) &&
            !(tbl.wr_en[1] && tbl.new_preg[1] == cmplt_preg)
    );

endmodule

// File: rename_ifs.sv
`timescale 1ns/1ps

// alias lookup and update between the group logic and the map table
interface map_if;
    // sources ordered lane0 src1, lane0 src2, lane1 src1, lane1 src2
    logic [2*rename_pkg::group_w-1:0][rename_pkg::arch_w-1:0] src_idx;
    logic [rename_pkg::group_w-1:0][rename_pkg::arch_w-1:0]   dst_idx;
    logic [rename_pkg::group_w-1:0]                           wr_en;
    logic [rename_pkg::group_w-1:0][rename_pkg::preg_w-1:0]   new_preg;
    logic                                                     update;

    logic [2*rename_pkg::group_w-1:0][rename_pkg::preg_w-1:0] src_preg;
    logic [2*rename_pkg::group_w-1:0]                         src_ready;
    logic [rename_pkg::group_w-1:0][rename_pkg::preg_w-1:0]   old_preg;

    modport lookup (
        output src_idx, dst_idx, wr_en, new_preg, update,
        input  src_preg, src_ready, old_preg
    );

    modport tbl (
        input  src_idx, dst_idx, wr_en, new_preg, update,
        output src_preg, src_ready, old_preg
    );
endinterface

// destination register allocation from the free pool
interface alloc_if;
    logic [1:0]                                             need;
    logic                                                   take;
    logic [rename_pkg::group_w-1:0][rename_pkg::preg_w-1:0] grant_preg;
    logic                                                   enough;

    modport request (output need, take, input grant_preg, enough);

    modport pool (input need, take, output grant_preg, enough);
endinterface

// File: rename_pkg.sv
package rename_pkg;

    // architectural and physical register file sizes
    localparam int arch_regs = 8;
    localparam int arch_w    = 3;
    localparam int phys_regs = 32;
    localparam int preg_w    = 5;

    // lanes per rename group, the bypass logic assumes two
    localparam int group_w = 2;

    localparam int imm_w = 14;
    localparam int uop_w = 24;

    // opcode with no destination write
    localparam logic [3:0] op_nop = 4'd0;

    // one micro-op word, opcode msb set means immediate form
    typedef union packed {
        struct packed {
            logic [3:0]        opcode;
            logic [arch_w-1:0] dst;
            logic [arch_w-1:0] src1;
            logic [arch_w-1:0] src2;
            logic [10:0]       pad;
        } reg_form;
        struct packed {
            logic [3:0]        opcode;
            logic [arch_w-1:0] dst;
            logic [arch_w-1:0] src1;
            logic [imm_w-1:0]  imm;
        } imm_form;
    } micro_op_u;

    // renamed op as handed to the back end
    typedef struct packed {
        logic [3:0]        opcode;
        logic              is_imm;
        logic [preg_w-1:0] dst_preg;
        logic [preg_w-1:0] src1_preg;
        logic              src1_ready;
        logic [preg_w-1:0] src2_preg;
        logic              src2_ready;
        logic [imm_w-1:0]  imm;
    } renamed_op_t;

    // after reset arch reg i sits in phys reg i, which holds a done value
    localparam logic [phys_regs-1:0] reset_done =
        {{(phys_regs - arch_regs){1'b0}}, {arch_regs{1'b1}}};
    localparam logic [phys_regs-1:0] reset_free = ~reset_done;

    function automatic logic [preg_w-1:0] reset_alias(input int unsigned arch);
        return preg_w'(arch);
    endfunction

endpackage
